// File: list.f
src/paddle_pkg.sv
src/frame_timer.sv
src/paddle_motion.sv
src/box_scanner.sv
src/paddle_renderer.sv
src/pong_paddles.sv
verification/tb_pong_paddles.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the pong_paddles testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf build
mkdir -p build

verilator --binary --timing --assert \
	-f list.f \
	--top-module tb_pong_paddles \
	-Mdir build \
	-o sim_tb_pong_paddles

# the log decides the result, so a stopped simulation still reaches the search
./build/sim_tb_pong_paddles > build/sim.log 2>&1 || true
cat build/sim.log

if grep -q -x -F '>>> PASS' build/sim.log; then
	exit 0
else
	exit 1
fi

// File: src/box_scanner.sv
// scans one PADDLE_W x PADDLE_H box, one pixel per cycle; start must not arrive mid-scan
`timescale 1ns/1ns

module box_scanner (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 start,
	input  paddle_pkg::x_coord_t org_x,
	input  paddle_pkg::y_coord_t org_y,
	output paddle_pkg::x_coord_t pix_x,
	output paddle_pkg::y_coord_t pix_y,
	output logic                 plot,
	output logic                 done
);

	localparam int COL_W = $clog2(paddle_pkg::PADDLE_W);
	localparam int ROW_W = $clog2(paddle_pkg::PADDLE_H);

	paddle_pkg::x_coord_t org_x_q;
	paddle_pkg::y_coord_t org_y_q;
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;

	// origin held for the whole scan
	always_ff @(posedge clk) begin
		if (start) begin
			org_x_q <= org_x;
			org_y_q <= org_y;
		end
	end

	// row-major walk, done the cycle after the last pixel
	always_ff @(posedge clk) begin
		if (!resetn) begin
			col <= '0;
			row <= '0;
			plot <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				col <= '0;
				row <= '0;
				plot <= 1'b1;
			end else if (plot) begin
				if (col == COL_W'(paddle_pkg::PADDLE_W - 1)) begin
					col <= '0;
					if (row == ROW_W'(paddle_pkg::PADDLE_H - 1)) begin
						row <= '0;
						plot <= 1'b0;
						done <= 1'b1;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	assign pix_x = org_x_q + paddle_pkg::x_coord_t'(col);
	assign pix_y = org_y_q + paddle_pkg::y_coord_t'(row);

	// the renderer waits for done before the next pass
	a_no_restart : assert property (
		@(posedge clk) disable iff (!resetn)
		start |-> !plot
	) else $error("scanner restarted mid-box");

	// origins from the motion limits keep every pixel on screen
	a_on_screen : assert property (
		@(posedge clk) disable iff (!resetn)
		plot |-> (pix_x < paddle_pkg::x_coord_t'(paddle_pkg::SCREEN_W)) &&
			(pix_y < paddle_pkg::y_coord_t'(paddle_pkg::SCREEN_H))
	) else $error("pixel off screen at (%0d, %0d)", pix_x, pix_y);

endmodule

// File: src/frame_timer.sv
// one-cycle tick every FRAME_CLKS clocks, first tick FRAME_CLKS cycles after reset release
`timescale 1ns/1ns

module frame_timer (
	input  logic clk,
	input  logic resetn,
	output logic frame_tick
);

	localparam int CNT_W = $clog2(paddle_pkg::FRAME_CLKS);

	logic [CNT_W-1:0] count;

	// down-counter, reloads on wrap
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= CNT_W'(paddle_pkg::FRAME_CLKS - 1);
			frame_tick <= 1'b0;
		end else begin
			if (count == '0) begin
				count <= CNT_W'(paddle_pkg::FRAME_CLKS - 1);
				frame_tick <= 1'b1;
			end else begin
				count <= count - 1'b1;
				frame_tick <= 1'b0;
			end
		end
	end

	// tick is a single-cycle pulse
	a_tick_single : assert property (
		@(posedge clk) disable iff (!resetn)
		frame_tick |=> !frame_tick
	) else $error("frame_tick held for more than one cycle");

endmodule

// File: src/paddle_motion.sv
// one paddle, rows only; column belongs to the renderer; buttons are plain levels, no debounce
`timescale 1ns/1ns

module paddle_motion (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 up,
	input  logic                 down,
	input  logic                 frame_tick,
	output paddle_pkg::y_coord_t cur_y,
	output paddle_pkg::y_coord_t prev_y
);

	paddle_pkg::move_state_t state;
	paddle_pkg::move_state_t next_state;

	// room to move, checked in 9 bits so the sum cannot wrap
	logic can_up;
	logic can_down;
	logic [8:0] below_y;

	assign below_y = {1'b0, cur_y} + 9'(paddle_pkg::STEP);
	assign can_up = (cur_y >= paddle_pkg::y_coord_t'(paddle_pkg::STEP));
	assign can_down = (below_y <= 9'(paddle_pkg::Y_MAX));

	// both or neither pressed means still
	always_comb begin
		next_state = paddle_pkg::MOVE_STILL;
		if (up && !down && can_up) begin
			next_state = paddle_pkg::MOVE_UP;
		end else if (down && !up && can_down) begin
			next_state = paddle_pkg::MOVE_DOWN;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= paddle_pkg::MOVE_STILL;
		end else begin
			state <= next_state;
		end
	end

	// position only changes on a frame tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cur_y <= paddle_pkg::y_coord_t'(paddle_pkg::Y_START);
			prev_y <= paddle_pkg::y_coord_t'(paddle_pkg::Y_START);
		end else if (frame_tick) begin
			prev_y <= cur_y;
			case (state)
				paddle_pkg::MOVE_UP: begin
					cur_y <= cur_y - paddle_pkg::y_coord_t'(paddle_pkg::STEP);
				end
				paddle_pkg::MOVE_DOWN: begin
					cur_y <= cur_y + paddle_pkg::y_coord_t'(paddle_pkg::STEP);
				end
				default: begin
					cur_y <= cur_y;
				end
			endcase
		end
	end

	// bound check across the state register and the position update
	a_y_in_range : assert property (
		@(posedge clk) disable iff (!resetn)
		cur_y <= paddle_pkg::y_coord_t'(paddle_pkg::Y_MAX)
	) else $error("paddle row %0d below Y_MAX", cur_y);

endmodule

// File: src/paddle_pkg.sv
// fixed 320x240 geometry, no per-instance overrides; FRAME_CLKS is sized for simulation only
package paddle_pkg;

	// screen geometry
	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;

	// paddle box, identical for both players
	localparam int PADDLE_W = 5;
	localparam int PADDLE_H = 40;

	// paddle columns
	localparam int LEFT_X = SCREEN_W / 32;
	localparam int RIGHT_X = SCREEN_W - PADDLE_W;

	// vertical travel limits
	localparam int Y_MAX = SCREEN_H - 1 - PADDLE_H;
	localparam int Y_START = SCREEN_H / 2;

	// rows per frame tick
	localparam int STEP = 4;

	// a board build raises this to clock rate / frame rate
	localparam int FRAME_CLKS = 1024;

	// screen column, 0..319
	typedef logic [8:0] x_coord_t;

	// screen row, 0..239
	typedef logic [7:0] y_coord_t;

	// 3-bit rgb pixel
	typedef logic [2:0] colour_t;

	localparam colour_t COLOUR_BACK = 3'd0;
	localparam colour_t COLOUR_PADDLE = 3'd7;

	// per-paddle direction
	typedef enum logic [1:0] {
		MOVE_STILL,
		MOVE_UP,
		MOVE_DOWN
	} move_state_t;

	// renderer pass sequence
	typedef enum logic [2:0] {
		R_IDLE,
		R_CLEAR_LEFT,
		R_DRAW_LEFT,
		R_CLEAR_RIGHT,
		R_DRAW_RIGHT
	} render_state_t;

endpackage

// File: src/paddle_renderer.sv
// four passes per tick, 800 pixels; the framebuffer must take one pixel per cycle, no back-pressure
`timescale 1ns/1ns

module paddle_renderer (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 frame_tick,
	input  paddle_pkg::y_coord_t left_y,
	input  paddle_pkg::y_coord_t left_prev_y,
	input  paddle_pkg::y_coord_t right_y,
	input  paddle_pkg::y_coord_t right_prev_y,
	output paddle_pkg::x_coord_t pixel_x,
	output paddle_pkg::y_coord_t pixel_y,
	output paddle_pkg::colour_t  colour,
	output logic                 plot
);

	paddle_pkg::render_state_t state;

	logic scan_start;
	logic scan_done;
	paddle_pkg::x_coord_t org_x;
	paddle_pkg::y_coord_t org_y;
	paddle_pkg::colour_t colour_q;

	// pass sequencer, start fires in the first cycle of each pass
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= paddle_pkg::R_IDLE;
			scan_start <= 1'b0;
			colour_q <= paddle_pkg::COLOUR_BACK;
		end else begin
			scan_start <= 1'b0;
			case (state)
				paddle_pkg::R_IDLE: begin
					if (frame_tick) begin
						state <= paddle_pkg::R_CLEAR_LEFT;
						scan_start <= 1'b1;
						colour_q <= paddle_pkg::COLOUR_BACK;
					end
				end
				paddle_pkg::R_CLEAR_LEFT: begin
					if (scan_done) begin
						state <= paddle_pkg::R_DRAW_LEFT;
						scan_start <= 1'b1;
						colour_q <= paddle_pkg::COLOUR_PADDLE;
					end
				end
				paddle_pkg::R_DRAW_LEFT: begin
					if (scan_done) begin
						state <= paddle_pkg::R_CLEAR_RIGHT;
						scan_start <= 1'b1;
						colour_q <= paddle_pkg::COLOUR_BACK;
					end
				end
				paddle_pkg::R_CLEAR_RIGHT: begin
					if (scan_done) begin
						state <= paddle_pkg::R_DRAW_RIGHT;
						scan_start <= 1'b1;
						colour_q <= paddle_pkg::COLOUR_PADDLE;
					end
				end
				paddle_pkg::R_DRAW_RIGHT: begin
					if (scan_done) begin
						state <= paddle_pkg::R_IDLE;
					end
				end
				default: begin
					state <= paddle_pkg::R_IDLE;
				end
			endcase
		end
	end

	// origin picked from the live rows; the tick has already moved them
	// by the time start is high
	always_comb begin
		case (state)
			paddle_pkg::R_DRAW_LEFT: begin
				org_x = paddle_pkg::x_coord_t'(paddle_pkg::LEFT_X);
				org_y = left_y;
			end
			paddle_pkg::R_CLEAR_RIGHT: begin
				org_x = paddle_pkg::x_coord_t'(paddle_pkg::RIGHT_X);
				org_y = right_prev_y;
			end
			paddle_pkg::R_DRAW_RIGHT: begin
				org_x = paddle_pkg::x_coord_t'(paddle_pkg::RIGHT_X);
				org_y = right_y;
			end
			default: begin
				org_x = paddle_pkg::x_coord_t'(paddle_pkg::LEFT_X);
				org_y = left_prev_y;
			end
		endcase
	end

	box_scanner scan0 (
		.clk    (clk),
		.resetn (resetn),
		.start  (scan_start),
		.org_x  (org_x),
		.org_y  (org_y),
		.pix_x  (pixel_x),
		.pix_y  (pixel_y),
		.plot   (plot),
		.done   (scan_done)
	);

	assign colour = colour_q;

	// every scanner pixel belongs to some pass
	a_plot_in_pass : assert property (
		@(posedge clk) disable iff (!resetn)
		plot |-> (state != paddle_pkg::R_IDLE)
	) else $error("pixel plotted while renderer idle");

endmodule

// File: src/pong_paddles.sv
// two-paddle display engine top; pixel port has no ready, one pixel per cycle while plot is high
`timescale 1ns/1ns

module pong_paddles (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 up_left,
	input  logic                 down_left,
	input  logic                 up_right,
	input  logic                 down_right,
	output paddle_pkg::x_coord_t pixel_x,
	output paddle_pkg::y_coord_t pixel_y,
	output paddle_pkg::colour_t  colour,
	output logic                 plot
);

	logic frame_tick;
	paddle_pkg::y_coord_t left_y;
	paddle_pkg::y_coord_t left_prev_y;
	paddle_pkg::y_coord_t right_y;
	paddle_pkg::y_coord_t right_prev_y;

	frame_timer timer0 (
		.clk        (clk),
		.resetn     (resetn),
		.frame_tick (frame_tick)
	);

	paddle_motion left0 (
		.clk        (clk),
		.resetn     (resetn),
		.up         (up_left),
		.down       (down_left),
		.frame_tick (frame_tick),
		.cur_y      (left_y),
		.prev_y     (left_prev_y)
	);

	paddle_motion right0 (
		.clk        (clk),
		.resetn     (resetn),
		.up         (up_right),
		.down       (down_right),
		.frame_tick (frame_tick),
		.cur_y      (right_y),
		.prev_y     (right_prev_y)
	);

	paddle_renderer render0 (
		.clk          (clk),
		.resetn       (resetn),
		.frame_tick   (frame_tick),
		.left_y       (left_y),
		.left_prev_y  (left_prev_y),
		.right_y      (right_y),
		.right_prev_y (right_prev_y),
		.pixel_x      (pixel_x),
		.pixel_y      (pixel_y),
		.colour       (colour),
		.plot         (plot)
	);

endmodule

// File: verification/tb_pong_paddles.sv
// buttons come from a fixed-seed LFSR and change only mid-run, so a tick never sees them mid-change
`timescale 1ns/1ns

module tb_pong_paddles;

	localparam int NUM_FRAMES = 60;
	localparam int RUN_PIXELS = paddle_pkg::PADDLE_W * paddle_pkg::PADDLE_H;
	localparam int FIRST_WAIT = paddle_pkg::FRAME_CLKS + 16;
	localparam int GAP_WAIT = 8;
	localparam int MAX_ERR_LINES = 20;
	localparam logic [31:0] SEED = 32'hb897430f;

	// left leans up early, right leans down early, so both limits get hit
	localparam int LEFT_UP_FRAMES = 50;
	localparam int RIGHT_DOWN_FRAMES = 35;

	logic clk;
	logic resetn;
	logic up_left;
	logic down_left;
	logic up_right;
	logic down_right;
	paddle_pkg::x_coord_t pixel_x;
	paddle_pkg::y_coord_t pixel_y;
	paddle_pkg::colour_t colour;
	logic plot;

	logic [31:0] lfsr;
	int model_left;
	int model_right;
	int checks_failed;
	int err_lines;
	int tests_passed;
	int tests_failed;
	int left_top_frame;
	int right_bottom_frame;
	bit timed_out;

	pong_paddles dut0 (
		.clk        (clk),
		.resetn     (resetn),
		.up_left    (up_left),
		.down_left  (down_left),
		.up_right   (up_right),
		.down_right (down_right),
		.pixel_x    (pixel_x),
		.pixel_y    (pixel_y),
		.colour     (colour),
		.plot       (plot)
	);

	always #4 clk = ~clk;

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		int i;
		bits = '0;
		for (i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// {up, down}: mostly the favoured direction, sometimes both or neither
	function automatic logic [1:0] button_pair(input logic [3:0] r, input bit favour_up);
		if (r <= 4'd12) begin
			return favour_up ? 2'b10 : 2'b01;
		end else if (r == 4'd13) begin
			return 2'b11;
		end
		return 2'b00;
	endfunction

	task automatic pick_buttons(input int frame);
		logic [31:0] r;
		take_bits(4, r);
		{up_left, down_left} = button_pair(r[3:0], frame <= LEFT_UP_FRAMES);
		take_bits(4, r);
		{up_right, down_right} = button_pair(r[3:0], frame > RIGHT_DOWN_FRAMES);
	endtask

	// paddle rule: one button moves a step if the whole box stays on screen
	function automatic int next_row(input int y, input logic up, input logic down);
		if (up && !down && y >= paddle_pkg::STEP) begin
			return y - paddle_pkg::STEP;
		end
		if (down && !up && y + paddle_pkg::STEP <= paddle_pkg::Y_MAX) begin
			return y + paddle_pkg::STEP;
		end
		return y;
	endfunction

	task automatic note_failure(input string msg);
		checks_failed++;
		$display("%s", msg);
	endtask

	task automatic check_x(input string name, input paddle_pkg::x_coord_t expected,
			input paddle_pkg::x_coord_t actual);
		if (actual !== expected) begin
			checks_failed++;
			if (err_lines < MAX_ERR_LINES) begin
				$display("ERR %s pixel_x: expected %0d, actual %0d", name, expected, actual);
				err_lines++;
			end
		end
	endtask

	task automatic check_y(input string name, input paddle_pkg::y_coord_t expected,
			input paddle_pkg::y_coord_t actual);
		if (actual !== expected) begin
			checks_failed++;
			if (err_lines < MAX_ERR_LINES) begin
				$display("ERR %s pixel_y: expected %0d, actual %0d", name, expected, actual);
				err_lines++;
			end
		end
	endtask

	task automatic check_colour(input string name, input paddle_pkg::colour_t expected,
			input paddle_pkg::colour_t actual);
		if (actual !== expected) begin
			checks_failed++;
			if (err_lines < MAX_ERR_LINES) begin
				$display("ERR %s colour: expected %0d, actual %0d", name, expected, actual);
				err_lines++;
			end
		end
	endtask

	// one box: wait for plot, then 200 row-major pixels, sampled on the falling edge
	task automatic check_run(input string name, input int org_x, input int org_y,
			input paddle_pkg::colour_t run_colour, input int wait_limit, input bit reshuffle,
			input int frame, output int waited, output bit ok);
		int i;
		ok = 1'b0;
		waited = 0;
		@(negedge clk);
		while (!plot && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!plot) begin
			timed_out = 1'b1;
			note_failure($sformatf("timeout: %s never started within %0d cycles", name, waited));
			return;
		end
		for (i = 0; i < RUN_PIXELS; i++) begin
			if (!plot) begin
				note_failure($sformatf("%s: plot dropped after %0d pixels", name, i));
				return;
			end
			check_x(name, paddle_pkg::x_coord_t'(org_x + i % paddle_pkg::PADDLE_W), pixel_x);
			check_y(name, paddle_pkg::y_coord_t'(org_y + i / paddle_pkg::PADDLE_W), pixel_y);
			check_colour(name, run_colour, colour);
			// new levels for the next frame, far from any tick
			if (reshuffle && i == RUN_PIXELS / 2) begin
				@(posedge clk);
				#1;
				pick_buttons(frame + 1);
			end
			@(negedge clk);
		end
		if (plot) begin
			note_failure($sformatf("%s: run longer than %0d pixels", name, RUN_PIXELS));
			return;
		end
		ok = 1'b1;
	endtask

	task automatic run_frame(input int frame, output bit ok);
		int prev_left;
		int prev_right;
		int waited;
		int errors_before;
		bit run_ok;
		ok = 1'b0;
		errors_before = checks_failed;
		prev_left = model_left;
		prev_right = model_right;
		model_left = next_row(model_left, up_left, down_left);
		model_right = next_row(model_right, up_right, down_right);
		// a push into the limit that must be refused this frame
		if (up_left && !down_left && prev_left < paddle_pkg::STEP && left_top_frame == 0) begin
			left_top_frame = frame;
		end
		if (down_right && !up_right && prev_right + paddle_pkg::STEP > paddle_pkg::Y_MAX
				&& right_bottom_frame == 0) begin
			right_bottom_frame = frame;
		end

		check_run($sformatf("frame %0d left erase", frame), paddle_pkg::LEFT_X, prev_left,
			paddle_pkg::COLOUR_BACK, FIRST_WAIT, 1'b1, frame, waited, run_ok);
		if (!run_ok) return;
		if (frame == 1 && waited < paddle_pkg::FRAME_CLKS) begin
			note_failure($sformatf("plot seen %0d cycles after reset, before the first tick",
				waited));
		end
		check_run($sformatf("frame %0d left draw", frame), paddle_pkg::LEFT_X, model_left,
			paddle_pkg::COLOUR_PADDLE, GAP_WAIT, 1'b0, frame, waited, run_ok);
		if (!run_ok) return;
		check_run($sformatf("frame %0d right erase", frame), paddle_pkg::RIGHT_X, prev_right,
			paddle_pkg::COLOUR_BACK, GAP_WAIT, 1'b0, frame, waited, run_ok);
		if (!run_ok) return;
		check_run($sformatf("frame %0d right draw", frame), paddle_pkg::RIGHT_X, model_right,
			paddle_pkg::COLOUR_PADDLE, GAP_WAIT, 1'b0, frame, waited, run_ok);
		if (!run_ok) return;
		ok = 1'b1;

		if (checks_failed == errors_before) begin
			tests_passed++;
			$display("frame %0d: left %0d -> %0d, right %0d -> %0d, 800 pixels ok",
				frame, prev_left, model_left, prev_right, model_right);
		end else begin
			tests_failed++;
			$display("frame %0d: %0d mismatches", frame, checks_failed - errors_before);
		end
	endtask

	initial begin : main_seq
		int frame;
		bit ok;
		clk = 1'b0;
		resetn = 1'b0;
		up_left = 1'b0;
		down_left = 1'b0;
		up_right = 1'b0;
		down_right = 1'b0;
		lfsr = SEED;
		model_left = paddle_pkg::Y_START;
		model_right = paddle_pkg::Y_START;
		checks_failed = 0;
		err_lines = 0;
		tests_passed = 0;
		tests_failed = 0;
		left_top_frame = 0;
		right_bottom_frame = 0;
		timed_out = 1'b0;

		repeat (5) @(posedge clk);
		#1;
		resetn = 1'b1;

		for (frame = 1; frame <= NUM_FRAMES; frame++) begin
			run_frame(frame, ok);
			if (!ok) begin
				tests_failed++;
				$display("frame %0d: aborted", frame);
				break;
			end
		end

		// limits: the model clamps, the draw rows above must have matched it
		if (left_top_frame != 0) begin
			tests_passed++;
			$display("left top limit: up push held at the top in frame %0d", left_top_frame);
		end else begin
			tests_failed++;
			$display("left paddle never pushed up against its top limit");
		end
		if (right_bottom_frame != 0) begin
			tests_passed++;
			$display("right bottom limit: down push held at the bottom in frame %0d",
				right_bottom_frame);
		end else begin
			tests_failed++;
			$display("right paddle never pushed down against its bottom limit");
		end

		$display("tests: %0d passed, %0d failed, %0d check failures",
			tests_passed, tests_failed, checks_failed);
		if (checks_failed == 0 && tests_failed == 0 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
